// File: hdl/sparcIsaPkg.sv
// Format-3 instruction field types, instruction word union and ALU op3 codes
`default_nettype none

package sparcIsaPkg;

	// Register index, 32 registers
	typedef logic [4:0] regIdx_t;

	// ALU opcode field
	typedef logic [5:0] op3_t;

	// Value of op for arithmetic and logic instructions
	localparam logic [1:0] opArith = 2'b10;

	// Base op3 codes, bit 4 set gives the cc variant
	localparam op3_t opAdd  = 6'd0;
	localparam op3_t opAnd  = 6'd1;
	localparam op3_t opOr   = 6'd2;
	localparam op3_t opXor  = 6'd3;
	localparam op3_t opSub  = 6'd4;
	localparam op3_t opAndn = 6'd5;
	localparam op3_t opOrn  = 6'd6;
	localparam op3_t opXnor = 6'd7;
	localparam op3_t opAddx = 6'd8;
	localparam op3_t opSubx = 6'd12;

	// Shifts, never touch the flags
	localparam op3_t opSll  = 6'd37;
	localparam op3_t opSrl  = 6'd38;
	localparam op3_t opSra  = 6'd39;

	// Register-operand layout (i = 0)
	typedef struct packed {
		logic [1:0] op;
		regIdx_t    rd;
		op3_t       op3;
		regIdx_t    rs1;
		logic       i;
		logic [7:0] asi;
		regIdx_t    rs2;
	} regForm_t;

	// Immediate-operand layout (i = 1)
	typedef struct packed {
		logic [1:0]  op;
		regIdx_t     rd;
		op3_t        op3;
		regIdx_t     rs1;
		logic        i;
		logic [12:0] simm13;
	} immForm_t;

	// Same 32-bit word seen through either layout
	typedef union packed {
		regForm_t regForm;
		immForm_t immForm;
	} instWord_u;

endpackage

`default_nettype wire

// File: hdl/sparcCorePkg.sv
// Core data word type and integer condition code struct
`default_nettype none

package sparcCorePkg;

	// Datapath word
	typedef logic [31:0] word_t;

	// Integer condition codes, N at the MSB
	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c;
	} icc_t;

endpackage

`default_nettype wire

// File: hdl/aluIf.sv
// ALU interface with issue and exec modports
`timescale 1ns/1ps
`default_nettype none

interface aluIf;

	// Request side, from the control block
	sparcIsaPkg::op3_t   op;
	sparcCorePkg::word_t a;
	sparcCorePkg::word_t b;
	logic                cin;

	// Response side, valid in the same cycle
	sparcCorePkg::word_t res;
	sparcCorePkg::icc_t  flags;
	logic                ccWrite;
	logic                legal;

	modport issue (output op, a, b, cin, input res, flags, ccWrite, legal);
	modport exec (input op, a, b, cin, output res, flags, ccWrite, legal);

endinterface

`default_nettype wire

// File: hdl/alu.sv
// Combinational 32-bit ALU with NZVC generation and op3 legality check
`timescale 1ns/1ps
`default_nettype none

module alu
(
	aluIf.exec bus
);

	// cc variant of codes 0 to 15
	logic ccVariant;
	// op3 with the cc bit stripped
	sparcIsaPkg::op3_t baseOp;
	// Sum or difference, top bit is carry or borrow
	logic [32:0] arith;
	sparcCorePkg::word_t res;
	logic legal;
	logic addClass;
	logic subClass;
	logic [4:0] shAmt;

	assign ccVariant = ~bus.op[5] & bus.op[4];
	assign baseOp = bus.op ^ {1'b0, ccVariant, 4'b0000};

	// Only the low 5 bits count
	assign shAmt = bus.b[4:0];

	always_comb
	begin
		arith = '0;
		res = '0;
		legal = 1'b1;
		addClass = 1'b0;
		subClass = 1'b0;
		case (baseOp)
			sparcIsaPkg::opAdd:
			begin
				arith = {1'b0, bus.a} + {1'b0, bus.b};
				res = arith[31:0];
				addClass = 1'b1;
			end
			sparcIsaPkg::opAddx:
			begin
				// Carry in from stored C
				arith = {1'b0, bus.a} + {1'b0, bus.b} + {32'd0, bus.cin};
				res = arith[31:0];
				addClass = 1'b1;
			end
			sparcIsaPkg::opSub:
			begin
				arith = {1'b0, bus.a} - {1'b0, bus.b};
				res = arith[31:0];
				subClass = 1'b1;
			end
			sparcIsaPkg::opSubx:
			begin
				arith = {1'b0, bus.a} - {1'b0, bus.b} - {32'd0, bus.cin};
				res = arith[31:0];
				subClass = 1'b1;
			end
			sparcIsaPkg::opAnd:
				res = bus.a & bus.b;
			sparcIsaPkg::opOr:
				res = bus.a | bus.b;
			sparcIsaPkg::opXor:
				res = bus.a ^ bus.b;
			// Second operand inverted
			sparcIsaPkg::opAndn:
				res = bus.a & ~bus.b;
			sparcIsaPkg::opOrn:
				res = bus.a | ~bus.b;
			sparcIsaPkg::opXnor:
				res = bus.a ^ ~bus.b;
			sparcIsaPkg::opSll:
				res = bus.a << shAmt;
			sparcIsaPkg::opSrl:
				res = bus.a >> shAmt;
			sparcIsaPkg::opSra:
				// Sign fill from bit 31
				res = sparcCorePkg::word_t'($signed(bus.a) >>> shAmt);
			default:
				legal = 1'b0;
		endcase
	end

	assign bus.res = res;
	assign bus.legal = legal;
	// Shifts have op3 bit 5 set, so never a cc write
	assign bus.ccWrite = ccVariant & legal;

	always_comb
	begin
		bus.flags.n = res[31];
		bus.flags.z = (res == '0);
		// Logic ops clear V and C
		bus.flags.v = 1'b0;
		bus.flags.c = 1'b0;
		if (addClass)
		begin
			// Like signs in, other sign out
			bus.flags.v = (bus.a[31] == bus.b[31]) && (res[31] != bus.a[31]);
			bus.flags.c = arith[32];
		end
		else if (subClass)
		begin
			// Unlike signs in, result sign differs from a
			bus.flags.v = (bus.a[31] != bus.b[31]) && (res[31] != bus.a[31]);
			// Borrow
			bus.flags.c = arith[32];
		end
	end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
// 32x32 register file, two async read ports, one write port, r0 hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module regFile
(
	input  wire                  clk,
	input  wire                  rstN,
	input  sparcIsaPkg::regIdx_t rdAddrA,
	input  sparcIsaPkg::regIdx_t rdAddrB,
	output sparcCorePkg::word_t  rdDataA,
	output sparcCorePkg::word_t  rdDataB,
	input  wire                  wrEn,
	input  sparcIsaPkg::regIdx_t wrAddr,
	input  sparcCorePkg::word_t  wrData
);

	sparcCorePkg::word_t regs [32];

	// All registers cleared on reset
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			regs <= '{default: '0};
		else if (wrEn && (wrAddr != '0))
			regs[wrAddr] <= wrData;
	end

	// Read ports, r0 forced to zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: hdl/execCtrl.sv
// Instruction decode, operand select, ALU drive, icc register and result pulses
`timescale 1ns/1ps
`default_nettype none

module execCtrl
(
	input  wire                    clk,
	input  wire                    rstN,
	input  wire                    instValid,
	input  sparcIsaPkg::instWord_u inst,
	output sparcIsaPkg::regIdx_t   rdAddrA,
	output sparcIsaPkg::regIdx_t   rdAddrB,
	input  sparcCorePkg::word_t    rdDataA,
	input  sparcCorePkg::word_t    rdDataB,
	output logic                   wrEn,
	output sparcIsaPkg::regIdx_t   wrAddr,
	output sparcCorePkg::word_t    wrData,
	aluIf.issue                    bus,
	output logic                   resultValid,
	output sparcCorePkg::word_t    result,
	output sparcCorePkg::icc_t     icc,
	output logic                   illegal
);

	sparcCorePkg::word_t simmExt;
	logic formatOk;
	logic execOk;

	// Register sources
	assign rdAddrA = inst.regForm.rs1;
	assign rdAddrB = inst.regForm.rs2;

	// Sign-extend simm13 from the immediate layout
	assign simmExt = {{19{inst.immForm.simm13[12]}}, inst.immForm.simm13};

	// ALU request
	assign bus.op = inst.regForm.op3;
	assign bus.a = rdDataA;
	assign bus.b = inst.regForm.i ? simmExt : rdDataB;
	// ADDX and SUBX consume stored carry
	assign bus.cin = icc.c;

	// Format 3 only
	assign formatOk = (inst.regForm.op == sparcIsaPkg::opArith);
	assign execOk = instValid & formatOk & bus.legal;

	// Writeback at the next edge, r0 skipped
	assign wrEn = execOk & (inst.regForm.rd != '0);
	assign wrAddr = inst.regForm.rd;
	assign wrData = bus.res;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			resultValid <= 1'b0;
			illegal <= 1'b0;
			result <= '0;
			icc <= '0;
		end
		else
		begin
			// One-cycle pulses, exactly one per valid instruction
			resultValid <= execOk;
			illegal <= instValid & ~(formatOk & bus.legal);
			if (execOk)
				result <= bus.res;
			// Flags only for cc variants
			if (execOk && bus.ccWrite)
				icc <= bus.flags;
		end
	end

endmodule

`default_nettype wire

// File: hdl/sparcExec.sv
// Execute unit top level with register file, control block and ALU
`timescale 1ns/1ps
`default_nettype none

module sparcExec
(
	input  wire         clk,
	input  wire         rstN,
	input  wire         instValid,
	input  wire  [31:0] inst,
	output logic        resultValid,
	output logic [31:0] result,
	output logic [3:0]  icc,
	output logic        illegal
);

	sparcIsaPkg::regIdx_t rdAddrA;
	sparcIsaPkg::regIdx_t rdAddrB;
	sparcCorePkg::word_t  rdDataA;
	sparcCorePkg::word_t  rdDataB;
	logic                 wrEn;
	sparcIsaPkg::regIdx_t wrAddr;
	sparcCorePkg::word_t  wrData;

	// Control to ALU
	aluIf aluBus ();

	regFile u_regFile
	(
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData)
	);

	execCtrl u_execCtrl
	(
		.clk         (clk),
		.rstN        (rstN),
		.instValid   (instValid),
		.inst        (inst),
		.rdAddrA     (rdAddrA),
		.rdAddrB     (rdAddrB),
		.rdDataA     (rdDataA),
		.rdDataB     (rdDataB),
		.wrEn        (wrEn),
		.wrAddr      (wrAddr),
		.wrData      (wrData),
		.bus         (aluBus.issue),
		.resultValid (resultValid),
		.result      (result),
		.icc         (icc),
		.illegal     (illegal)
	);

	alu u_alu
	(
		.bus (aluBus.exec)
	);

endmodule

`default_nettype wire

// File: tests/tbClock.sv
// Free-running 10 ns testbench clock
`timescale 1ns/1ps
`default_nettype none

module tbClock
(
	output logic clk
);

	initial
		clk = 1'b0;

	// Half period 5 ns
	always
		#5 clk = ~clk;

endmodule

`default_nettype wire

// File: tests/sparcExec_assert.sv
// Concurrent checks on result pulses and icc hold, bound into execCtrl
`timescale 1ns/1ps
`default_nettype none

module execCtrlAssert
(
	input wire        clk,
	input wire        rstN,
	input wire        instValid,
	input wire [31:0] inst,
	input wire        resultValid,
	input wire        illegal,
	input wire [3:0]  icc
);

	// Never both pulses at once
	pulseExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(resultValid && illegal))
		else $error("resultValid and illegal high together");

	// One cycle wide unless another instruction follows
	validPulse: assert property (@(posedge clk) disable iff (!rstN)
		(resultValid && !instValid) |=> !resultValid)
		else $error("resultValid held without a new instruction");

	illegalPulse: assert property (@(posedge clk) disable iff (!rstN)
		(illegal && !instValid) |=> !illegal)
		else $error("illegal held without a new instruction");

	// icc moves only after a cc-variant result, op3 bit 4 set and bit 5 clear
	iccHold: assert property (@(posedge clk) disable iff (!rstN)
		!(resultValid && $past(inst[23] && !inst[24])) |-> $stable(icc))
		else $error("icc changed without a cc write");

endmodule

bind execCtrl execCtrlAssert u_execCtrlAssert
(
	.clk         (clk),
	.rstN        (rstN),
	.instValid   (instValid),
	.inst        (inst),
	.resultValid (resultValid),
	.illegal     (illegal),
	.icc         (icc)
);

`default_nettype wire

// File: tests/sparcExecTb.sv
// Directed-test testbench for the execute unit with register and icc model
`timescale 1ns/1ps
`default_nettype none

module sparcExecTb;

	logic        clk;
	logic        rstN;
	logic        instValid;
	logic [31:0] inst;
	logic        resultValid;
	logic [31:0] result;
	logic [3:0]  icc;
	logic        illegal;

	// Model of architectural state
	logic [31:0] mRegs [32];
	logic [3:0]  mIcc;
	logic [31:0] mResult;
	string       testName;
	int          errCount;
	int          cycles = 0;

	tbClock u_tbClock (.clk(clk));

	sparcExec u_sparcExec
	(
		.clk         (clk),
		.rstN        (rstN),
		.instValid   (instValid),
		.inst        (inst),
		.resultValid (resultValid),
		.result      (result),
		.icc         (icc),
		.illegal     (illegal)
	);

	task automatic stopRun();
		$display("TB FAILED");
		$fatal(1);
	endtask

	// Tests run about 500 cycles
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= 2000)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycles);
			stopRun();
		end
	end

	task automatic checkVal(input string what, input logic [31:0] expVal,
		input logic [31:0] actVal);
		assert (actVal === expVal)
		else
		begin
			$display("FAILED %s: %s expected %08h actual %08h", testName, what, expVal, actVal);
			errCount++;
			stopRun();
		end
	endtask

	function automatic logic [5:0] ccOf(input logic [5:0] op3);
		return op3 | 6'h10;
	endfunction

	// Reference ALU from the flag rules
	task automatic modelAlu(input logic [5:0] op3, input logic [31:0] a, input logic [31:0] b,
		input logic cin, output logic [31:0] res, output logic [3:0] nzvc,
		output logic ok, output logic ccw);
		logic [5:0]  base;
		logic [32:0] wide;
		logic        v;
		logic        c;
		ccw = (op3 >= 6'd16) && (op3 <= 6'd28);
		base = ccw ? op3 - 6'd16 : op3;
		ok = 1'b1;
		v = 1'b0;
		c = 1'b0;
		res = '0;
		case (base)
			6'd0, 6'd8:
			begin
				wide = {1'b0, a} + {1'b0, b} + ((base == 6'd8) ? {32'd0, cin} : 33'd0);
				res = wide[31:0];
				c = wide[32];
				v = (a[31] == b[31]) && (res[31] != a[31]);
			end
			6'd4, 6'd12:
			begin
				// Borrow when subtrahend plus carry exceeds a
				wide = {1'b0, b} + ((base == 6'd12) ? {32'd0, cin} : 33'd0);
				res = a - wide[31:0];
				c = {1'b0, a} < wide;
				v = (a[31] != b[31]) && (res[31] != a[31]);
			end
			6'd1: res = a & b;
			6'd2: res = a | b;
			6'd3: res = a ^ b;
			6'd5: res = a & ~b;
			6'd6: res = a | ~b;
			6'd7: res = ~(a ^ b);
			6'd37: res = a << b[4:0];
			6'd38: res = a >> b[4:0];
			6'd39: res = 32'($signed(a) >>> b[4:0]);
			default: ok = 1'b0;
		endcase
		ccw = ccw && ok;
		nzvc = {res[31], res == 32'd0, v, c};
	endtask

	// Drive at a falling edge, check one cycle later
	task automatic issue(input logic [1:0] op, input logic [4:0] rd, input logic [5:0] op3,
		input logic [4:0] rs1, input logic i, input logic [12:0] low);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [3:0]  nzvc;
		logic        ok;
		logic        ccw;
		a = mRegs[rs1];
		b = i ? {{19{low[12]}}, low} : mRegs[low[4:0]];
		modelAlu(op3, a, b, mIcc[0], res, nzvc, ok, ccw);
		ok = ok && (op == 2'b10);
		instValid = 1'b1;
		inst = {op, rd, op3, rs1, i, low};
		if (ok)
		begin
			if (rd != 5'd0)
				mRegs[rd] = res;
			if (ccw)
				mIcc = nzvc;
			mResult = res;
		end
		@(negedge clk);
		checkVal("resultValid", 32'(ok), 32'(resultValid));
		checkVal("illegal", 32'(!ok), 32'(illegal));
		checkVal("result", mResult, result);
		checkVal("icc", 32'(mIcc), 32'(icc));
	endtask

	task automatic regOp(input logic [5:0] op3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		issue(2'b10, rd, op3, rs1, 1'b0, {8'd0, rs2});
	endtask

	task automatic immOp(input logic [5:0] op3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [12:0] simm);
		issue(2'b10, rd, op3, rs1, 1'b1, simm);
	endtask

	// r0 minus 1 leaves N and C set
	task automatic presetIcc();
		immOp(ccOf(sparcIsaPkg::opSub), 5'd0, 5'd0, 13'd1);
	endtask

	task automatic idle();
		instValid = 1'b0;
		inst = '0;
		@(negedge clk);
		checkVal("idle resultValid", 32'd0, 32'(resultValid));
		checkVal("idle illegal", 32'd0, 32'(illegal));
	endtask

	// Build a full word from 11, 11 and 10 bit pieces
	task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
		immOp(sparcIsaPkg::opOr, rd, 5'd0, {2'b00, v[31:21]});
		immOp(sparcIsaPkg::opSll, rd, rd, 13'd11);
		immOp(sparcIsaPkg::opOr, rd, rd, {2'b00, v[20:10]});
		immOp(sparcIsaPkg::opSll, rd, rd, 13'd10);
		immOp(sparcIsaPkg::opOr, rd, rd, {3'b000, v[9:0]});
		checkVal("loaded value", v, result);
	endtask

	task automatic resetTest();
		testName = "reset";
		checkVal("resultValid", 32'd0, 32'(resultValid));
		checkVal("illegal", 32'd0, 32'(illegal));
		checkVal("icc", 32'd0, 32'(icc));
		checkVal("result", 32'd0, result);
		for (int k = 0; k < 32; k++)
		begin
			regOp(sparcIsaPkg::opAdd, 5'(k), 5'(k), 5'd0);
			checkVal("cleared register", 32'd0, result);
		end
		idle();
	endtask

	task automatic logicTest();
		logic [5:0]  ops [6];
		logic [12:0] simm;
		ops = '{sparcIsaPkg::opAnd, sparcIsaPkg::opOr, sparcIsaPkg::opXor,
			sparcIsaPkg::opAndn, sparcIsaPkg::opOrn, sparcIsaPkg::opXnor};
		testName = "logic";
		for (int n = 0; n < 4; n++)
		begin
			loadReg(5'd1, $urandom());
			loadReg(5'd2, $urandom());
			foreach (ops[k])
			begin
				simm = 13'($urandom());
				regOp(ccOf(ops[k]), 5'd3, 5'd1, 5'd2);
				// C set before each plain op, a logic flag write would clear it
				presetIcc();
				regOp(ops[k], 5'd4, 5'd1, 5'd2);
				immOp(ccOf(ops[k]), 5'd5, 5'd1, simm);
				presetIcc();
				immOp(ops[k], 5'd6, 5'd3, simm);
			end
		end
		// Complement gives zero
		loadReg(5'd2, ~mRegs[1]);
		regOp(ccOf(sparcIsaPkg::opAnd), 5'd3, 5'd1, 5'd2);
		checkVal("andcc zero flags", 32'h4, 32'(icc));
		idle();
	endtask

	task automatic edgePair(input logic [31:0] a, input logic [31:0] b,
		input logic [3:0] addIcc, input logic [3:0] subIcc);
		loadReg(5'd1, a);
		loadReg(5'd2, b);
		regOp(ccOf(sparcIsaPkg::opAdd), 5'd3, 5'd1, 5'd2);
		checkVal("addcc nzvc", 32'(addIcc), 32'(icc));
		regOp(ccOf(sparcIsaPkg::opSub), 5'd4, 5'd1, 5'd2);
		checkVal("subcc nzvc", 32'(subIcc), 32'(icc));
	endtask

	task automatic edgeTest();
		testName = "add sub edges";
		edgePair(32'h7fff_ffff, 32'h0000_0001, 4'b1010, 4'b0000);
		edgePair(32'hffff_ffff, 32'h0000_0001, 4'b0101, 4'b1000);
		edgePair(32'h8000_0000, 32'h8000_0000, 4'b0111, 4'b0100);
		edgePair(32'h0000_0000, 32'h0000_0001, 4'b0000, 4'b1001);
		edgePair(32'h8000_0000, 32'h0000_0001, 4'b1000, 4'b0010);
		idle();
	endtask

	task automatic carryTest();
		testName = "carry chain";
		loadReg(5'd1, 32'hffff_ffff);
		loadReg(5'd2, 32'h0000_0001);
		loadReg(5'd3, 32'h0000_0001);
		loadReg(5'd4, 32'h0000_0000);
		// 64-bit add {r2,r1} + {r4,r3}
		regOp(ccOf(sparcIsaPkg::opAdd), 5'd5, 5'd1, 5'd3);
		regOp(ccOf(sparcIsaPkg::opAddx), 5'd6, 5'd2, 5'd4);
		checkVal("addx high word", 32'd2, result);
		regOp(sparcIsaPkg::opAddx, 5'd7, 5'd6, 5'd5);
		// 64-bit 0 - 1 borrows through the high word
		regOp(ccOf(sparcIsaPkg::opSub), 5'd8, 5'd4, 5'd3);
		regOp(ccOf(sparcIsaPkg::opSubx), 5'd9, 5'd4, 5'd4);
		checkVal("subx high word", 32'hffff_ffff, result);
		regOp(sparcIsaPkg::opSubx, 5'd10, 5'd9, 5'd8);
		for (int n = 0; n < 3; n++)
		begin
			loadReg(5'd1, $urandom());
			loadReg(5'd2, $urandom());
			regOp(ccOf(sparcIsaPkg::opAdd), 5'd11, 5'd1, 5'd2);
			regOp(ccOf(sparcIsaPkg::opAddx), 5'd12, 5'd11, 5'd1);
			regOp(ccOf(sparcIsaPkg::opSubx), 5'd13, 5'd12, 5'd2);
		end
		idle();
	endtask

	task automatic shiftTest();
		logic [31:0] val;
		logic [31:0] amt;
		testName = "shift";
		for (int n = 0; n < 3; n++)
		begin
			val = $urandom() | 32'h8000_0000;
			amt = $urandom();
			loadReg(5'd1, val);
			loadReg(5'd2, amt);
			// Known nonzero icc to watch
			presetIcc();
			regOp(sparcIsaPkg::opSll, 5'd3, 5'd1, 5'd2);
			checkVal("sll", val << amt[4:0], result);
			regOp(sparcIsaPkg::opSrl, 5'd4, 5'd1, 5'd2);
			checkVal("srl", val >> amt[4:0], result);
			regOp(sparcIsaPkg::opSra, 5'd5, 5'd1, 5'd2);
			// Negative value, so ones shift in
			checkVal("sra", ~(~val >> amt[4:0]), result);
			immOp(sparcIsaPkg::opSra, 5'd6, 5'd1, 13'($urandom()));
			checkVal("icc held", 32'h9, 32'(icc));
		end
		idle();
	endtask

	task automatic illegalTest();
		logic [5:0] bad [5];
		bad = '{6'd9, 6'd13, 6'd25, 6'd36, 6'd63};
		testName = "illegal";
		loadReg(5'd5, 32'h1234_5678);
		presetIcc();
		foreach (bad[k])
			regOp(bad[k], 5'd5, 5'd5, 5'd5);
		// Op field values 0, 1 and 3
		for (int f = 0; f < 4; f++)
		begin
			if (f != 2)
				issue(2'(f), 5'd5, sparcIsaPkg::opAdd, 5'd5, 1'b1, 13'd3);
		end
		immOp(sparcIsaPkg::opOr, 5'd0, 5'd0, 13'd77);
		regOp(sparcIsaPkg::opAdd, 5'd6, 5'd0, 5'd0);
		checkVal("r0 read", 32'd0, result);
		regOp(sparcIsaPkg::opOr, 5'd7, 5'd5, 5'd0);
		checkVal("r5 kept", 32'h1234_5678, result);
		checkVal("icc kept", 32'h9, 32'(icc));
		idle();
	endtask

	initial
	begin
		void'($urandom(32'hd139_577a));
		rstN = 1'b0;
		instValid = 1'b0;
		inst = '0;
		errCount = 0;
		mIcc = '0;
		mResult = '0;
		testName = "init";
		foreach (mRegs[k])
			mRegs[k] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		resetTest();
		logicTest();
		edgeTest();
		carryTest();
		shiftTest();
		illegalTest();
		if (errCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sparcExec.f
hdl/sparcIsaPkg.sv
hdl/sparcCorePkg.sv
hdl/aluIf.sv
hdl/alu.sv
hdl/regFile.sv
hdl/execCtrl.sv
hdl/sparcExec.sv
tests/tbClock.sv
tests/sparcExec_assert.sv
tests/sparcExecTb.sv

// File: Makefile
# Verilator build and run of the execute unit testbench

SRCS := $(shell cat sparcExec.f)

.PHONY: run clean

run: obj_dir/VsparcExecTb
	./obj_dir/VsparcExecTb | tee sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi
	@grep -q "TB PASSED" sim.log

obj_dir/VsparcExecTb: sparcExec.f $(SRCS)
	verilator --binary --timing --assert --top-module sparcExecTb \
		-f sparcExec.f -o VsparcExecTb

clean:
	rm -rf obj_dir sim.log
